// ==== hw/rv_core_pkg.sv ====
// Shared widths, encodings and funct constants; imported by every core module and the testbench
`default_nettype none

package rv_core_pkg;

    // Data path and address width
    localparam int xlen = 32;

    // Register index width, 32 architectural registers
    localparam int reg_addr_w = 5;

    // Base opcodes handled by the core, instr[6:0]
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // ALU operation select
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_or  = 3'b011,
        alu_slt = 3'b101
    } alu_op_e;

    // Immediate format select for the extender
    typedef enum logic [1:0] {
        imm_i = 2'b00,
        imm_s = 2'b01,
        imm_b = 2'b10,
        imm_j = 2'b11
    } imm_src_e;

    // Register write-back source
    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01,
        res_pc4 = 2'b10
    } result_src_e;

    // funct3 codes for the supported ALU operations
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    // Instruction bit that selects sub over add (funct7 bit 5)
    localparam int funct7_sub_bit = 30;

endpackage

`default_nettype wire

// ==== hw/imm_extend.sv ====
// Immediate extender for the core datapath; builds the 32-bit immediate from the instruction
`timescale 1ns/1ps
`default_nettype none

module imm_extend (
    input  logic [31:7]                  instr,
    input  rv_core_pkg::imm_src_e        imm_src,
    output logic [rv_core_pkg::xlen-1:0] imm_ext
);

    import rv_core_pkg::*;

    always_comb begin
        case (imm_src)
            // Loads and ALU immediates
            imm_i: begin
                imm_ext = {{20{instr[31]}}, instr[31:20]};
            end
            // Stores, offset split across two fields
            imm_s: begin
                imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // Branches, halfword aligned
            imm_b: begin
                imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            // jal, 21-bit signed offset
            imm_j: begin
                imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm_ext = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/control_decoder.sv ====
// Control decoder for the single-cycle core; turns opcode and funct fields into datapath controls
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
    input  logic [31:0]              instr,
    input  logic                     zero,
    output logic                     reg_write,
    output logic                     alu_src,
    output logic                     mem_write,
    output rv_core_pkg::result_src_e result_src,
    output rv_core_pkg::imm_src_e    imm_src,
    output rv_core_pkg::alu_op_e     alu_op,
    output logic                     pc_src
);

    import rv_core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alu_decode;
    logic       branch;
    logic       jump;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // Main decoder
    always_comb begin
        reg_write  = 1'b0;
        alu_src    = 1'b0;
        mem_write  = 1'b0;
        result_src = res_alu;
        imm_src    = imm_i;
        alu_decode = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        case (opcode)
            op_load: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                result_src = res_mem;
            end
            op_store: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                imm_src   = imm_s;
            end
            op_reg: begin
                reg_write  = 1'b1;
                alu_decode = 1'b1;
            end
            op_imm: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                alu_decode = 1'b1;
            end
            op_branch: begin
                imm_src = imm_b;
                branch  = 1'b1;
            end
            op_jal: begin
                reg_write  = 1'b1;
                result_src = res_pc4;
                imm_src    = imm_j;
                jump       = 1'b1;
            end
            default: begin
                // Unknown opcodes keep every write off
            end
        endcase
    end

    // ALU decoder, beq compares through a subtract
    always_comb begin
        alu_op = alu_add;
        if (branch) begin
            alu_op = alu_sub;
        end else if (alu_decode) begin
            case (funct3)
                funct3_add_sub: begin
                    // Bit 30 selects sub only in the register form
                    if ((opcode == op_reg) && instr[funct7_sub_bit]) begin
                        alu_op = alu_sub;
                    end else begin
                        alu_op = alu_add;
                    end
                end
                funct3_slt: begin
                    alu_op = alu_slt;
                end
                funct3_or: begin
                    alu_op = alu_or;
                end
                funct3_and: begin
                    alu_op = alu_and;
                end
                default: begin
                    alu_op = alu_add;
                end
            endcase
        end
    end

    assign pc_src = (branch & zero) | jump;

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
// Register file for the core; 32 x 32-bit registers with two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [rv_core_pkg::reg_addr_w-1:0] read_addr1,
    input  logic [rv_core_pkg::reg_addr_w-1:0] read_addr2,
    input  logic [rv_core_pkg::reg_addr_w-1:0] write_addr,
    input  logic [rv_core_pkg::xlen-1:0]       write_data,
    input  logic                               write_enable,
    output logic [rv_core_pkg::xlen-1:0]       read_data1,
    output logic [rv_core_pkg::xlen-1:0]       read_data2
);

    import rv_core_pkg::*;

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    // Writes to x0 are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // Combinational reads, x0 hard-wired to zero
    assign read_data1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
    assign read_data2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
// ALU for the core datapath; add, sub, and, or and signed set-less-than with a zero flag
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_core_pkg::xlen-1:0] a,
    input  logic [rv_core_pkg::xlen-1:0] b,
    input  rv_core_pkg::alu_op_e         op,
    output logic [rv_core_pkg::xlen-1:0] result,
    output logic                         zero
);

    import rv_core_pkg::*;

    logic [xlen-1:0] diff;
    logic            less;

    // Shared subtractor for sub
    assign diff = a - b;

    // Signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = diff;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_slt: begin
                result = {{(xlen - 1){1'b0}}, less};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // beq compares through a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
// Datapath of the single-cycle core; PC, register file, ALU, extender and result selection
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [31:0]                  instr,
    input  logic [rv_core_pkg::xlen-1:0] read_data,
    input  logic                         reg_write,
    input  logic                         alu_src,
    input  rv_core_pkg::result_src_e     result_src,
    input  rv_core_pkg::imm_src_e        imm_src,
    input  rv_core_pkg::alu_op_e         alu_op,
    input  logic                         pc_src,
    output logic                         zero,
    output logic [rv_core_pkg::xlen-1:0] pc,
    output logic [rv_core_pkg::xlen-1:0] data_addr,
    output logic [rv_core_pkg::xlen-1:0] write_data
);

    import rv_core_pkg::*;

    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] result;

    // Program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + xlen'(4);
    assign pc_target = pc + imm_ext;

    // Branch or jal target when taken, else fall through
    assign pc_next = pc_src ? pc_target : pc_plus4;

    register_file rf_i (
        .clk          (clk),
        .reset        (reset),
        .read_addr1   (instr[19:15]),
        .read_addr2   (instr[24:20]),
        .write_addr   (instr[11:7]),
        .write_data   (result),
        .write_enable (reg_write),
        .read_data1   (src_a),
        .read_data2   (rd2)
    );

    imm_extend ext_i (
        .instr   (instr[31:7]),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

    // Second operand is rs2 or the immediate
    assign src_b = alu_src ? imm_ext : rd2;

    alu alu_i (
        .a      (src_a),
        .b      (src_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    // Write-back select
    always_comb begin
        case (result_src)
            res_alu: begin
                result = alu_result;
            end
            res_mem: begin
                result = read_data;
            end
            res_pc4: begin
                result = pc_plus4;
            end
            default: begin
                result = alu_result;
            end
        endcase
    end

    // Memory address from the ALU, store data straight from rs2
    assign data_addr  = alu_result;
    assign write_data = rd2;

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
// Top level of the RV32I subset core; connects the decoder and datapath to the memory ports
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [31:0]                  instr,
    input  logic [rv_core_pkg::xlen-1:0] read_data,
    output logic [rv_core_pkg::xlen-1:0] pc,
    output logic [rv_core_pkg::xlen-1:0] data_addr,
    output logic [rv_core_pkg::xlen-1:0] write_data,
    output logic                         mem_write
);

    import rv_core_pkg::*;

    logic        reg_write;
    logic        alu_src;
    logic        pc_src;
    logic        zero;
    result_src_e result_src;
    imm_src_e    imm_src;
    alu_op_e     alu_op;

    control_decoder dec_i (
        .instr      (instr),
        .zero       (zero),
        .reg_write  (reg_write),
        .alu_src    (alu_src),
        .mem_write  (mem_write),
        .result_src (result_src),
        .imm_src    (imm_src),
        .alu_op     (alu_op),
        .pc_src     (pc_src)
    );

    datapath dp_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .read_data  (read_data),
        .reg_write  (reg_write),
        .alu_src    (alu_src),
        .result_src (result_src),
        .imm_src    (imm_src),
        .alu_op     (alu_op),
        .pc_src     (pc_src),
        .zero       (zero),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data)
    );

endmodule

`default_nettype wire

// ==== include/rv_core_program.svh ====
// Test program, expected stores and taken-branch table; included inside the core testbench module
`ifndef rv_core_program_svh
`define rv_core_program_svh

// Program ends in a jal to itself at this address
localparam logic [31:0] end_pc = 32'd148;
// Stores go around this base, held in x9
localparam logic [31:0] store_base = 32'h0000_00c0;
// funct3 for word loads and stores
localparam logic [2:0] word_f3 = 3'b010;

logic [31:0]     imem [64];
int              prog_count;
logic [xlen-1:0] exp_addr_q [$];
logic [xlen-1:0] exp_data_q [$];
logic [xlen-1:0] jump_from_q [$];
logic [xlen-1:0] jump_to_q [$];

function automatic logic [31:0] r_type(input logic [2:0] f3, input logic sub,
                                       input int rd, input int rs1, input int rs2);
    logic [31:0] word;
    word = {7'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), op_reg};
    word[funct7_sub_bit] = sub;
    return word;
endfunction

function automatic logic [31:0] i_type(input opcode_e op, input logic [2:0] f3,
                                       input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), word_f3, v[4:0], op_store};
endfunction

// beq only, funct3 is zero
function automatic logic [31:0] b_type(input int rs1, input int rs2, input int imm);
    logic [12:0] v;
    v = 13'(imm);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'b000, v[4:1], v[11], op_branch};
endfunction

function automatic logic [31:0] j_type(input int rd, input int imm);
    logic [20:0] v;
    v = 21'(imm);
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), op_jal};
endfunction

task automatic emit(input logic [31:0] word);
    imem[prog_count] = word;
    prog_count++;
endtask

task automatic expect_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
endtask

task automatic expect_jump(input logic [xlen-1:0] from_pc, input logic [xlen-1:0] to_pc);
    jump_from_q.push_back(from_pc);
    jump_to_q.push_back(to_pc);
endtask

// loaded_word is the preset data memory word at byte address 64
task automatic build_program(input logic [xlen-1:0] loaded_word);
    for (int i = 0; i < 64; i++) begin
        imem[i] = i_type(op_imm, funct3_add_sub, 0, 0, 0);
    end
    prog_count = 0;
    emit(i_type(op_imm, funct3_add_sub, 1, 0, 5));
    emit(i_type(op_imm, funct3_add_sub, 2, 0, -3));
    emit(i_type(op_imm, funct3_add_sub, 9, 0, 192));
    emit(r_type(funct3_add_sub, 1'b0, 3, 1, 2));
    emit(r_type(funct3_add_sub, 1'b1, 4, 1, 2));
    emit(r_type(funct3_and, 1'b0, 5, 1, 2));
    emit(r_type(funct3_or, 1'b0, 6, 1, 2));
    emit(r_type(funct3_slt, 1'b0, 7, 2, 1));
    emit(r_type(funct3_slt, 1'b0, 8, 1, 2));
    emit(s_type(3, 9, 0));
    emit(s_type(4, 9, 4));
    emit(s_type(5, 9, -4));
    emit(s_type(6, 9, -8));
    emit(s_type(7, 9, 8));
    emit(s_type(8, 9, 12));
    emit(i_type(op_imm, funct3_and, 10, 2, -16));
    emit(i_type(op_imm, funct3_or, 11, 1, -256));
    emit(i_type(op_imm, funct3_slt, 12, 2, -2));
    emit(i_type(op_imm, funct3_add_sub, 13, 2, -2045));
    emit(s_type(10, 9, 16));
    emit(s_type(11, 9, 20));
    emit(s_type(12, 9, 24));
    emit(s_type(13, 9, -12));
    emit(i_type(op_load, word_f3, 14, 0, 64));
    emit(s_type(14, 9, 28));
    // Write to x0, then store x0
    emit(i_type(op_imm, funct3_add_sub, 0, 1, 7));
    emit(s_type(0, 9, 32));
    // lui x1 is not supported and must leave x1 alone
    emit({20'hfffff, 5'd1, 7'b0110111});
    emit(s_type(1, 9, 36));
    emit(b_type(1, 2, 8));
    emit(b_type(1, 1, 16));
    emit(i_type(op_imm, funct3_add_sub, 15, 0, 1));
    emit(j_type(16, 16));
    emit(s_type(1, 9, 44));
    emit(b_type(2, 2, -8));
    emit(s_type(2, 9, 48));
    emit(s_type(16, 9, 40));
    emit(j_type(0, 0));

    // Values follow from x1 = 5 and x2 = -3
    expect_store(store_base, 32'(5 + (-3)));
    expect_store(store_base + 4, 32'(5 - (-3)));
    expect_store(store_base - 4, 32'(5) & 32'(-3));
    expect_store(store_base - 8, 32'(5) | 32'(-3));
    expect_store(store_base + 8, 32'd1);
    expect_store(store_base + 12, 32'd0);
    expect_store(store_base + 16, 32'(-3) & 32'(-16));
    expect_store(store_base + 20, 32'(5) | 32'(-256));
    expect_store(store_base + 24, 32'd1);
    expect_store(store_base - 12, 32'(-3 + (-2045)));
    expect_store(store_base + 28, loaded_word);
    expect_store(store_base + 32, 32'd0);
    expect_store(store_base + 36, 32'd5);
    // Link of the jal at 128
    expect_store(store_base + 40, 32'd132);

    expect_jump(32'd120, 32'd136);
    expect_jump(32'd136, 32'd128);
    expect_jump(32'd128, 32'd144);
    expect_jump(end_pc, end_pc);
endtask

`endif

// ==== tests/rv_core_tb.sv ====
// Testbench for the RV32I subset core; runs the included program and checks stores and PC flow
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    import rv_core_pkg::*;

    localparam int reset_cycles = 10;
    localparam int dmem_words = 64;

    logic            clk;
    logic            reset;
    logic [31:0]     instr;
    logic [xlen-1:0] read_data;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] data_addr;
    logic [xlen-1:0] write_data;
    logic            mem_write;

    logic [xlen-1:0] dmem [dmem_words];
    logic [xlen-1:0] exp_pc;
    logic [xlen-1:0] load_word;
    int unsigned     seed;
    int              store_idx;
    int              timeout_limit;
    logic            reached_end;

    `include "rv_core_program.svh"

    rv_core_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_write  (mem_write)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign instr     = imem[pc[7:2]];
    assign read_data = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (mem_write && !reset) begin
            dmem[data_addr[7:2]] <= write_data;
        end
    end

    function automatic logic [xlen-1:0] fill_word(input int index);
        return {8'hd4, 8'(index), 8'(~index), 8'(index * 29)};
    endfunction

    // Next PC from the taken-branch table, else PC+4
    function automatic logic [xlen-1:0] predict_next_pc(input logic [xlen-1:0] cur);
        for (int i = 0; i < jump_from_q.size(); i++) begin
            if (jump_from_q[i] == cur) begin
                return jump_to_q[i];
            end
        end
        return cur + 4;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] actual,
                              input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s actual=0x%08h expected=0x%08h",
                $time, name, actual, expected));
        end
    endtask

    task automatic check_pc(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH time=%0t signal=pc actual=0x%08h expected=0x%08h",
                $time, actual, expected));
        end
    endtask

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run($sformatf("Program did not reach its end loop within %0d cycles",
            timeout_limit));
    end

    initial begin
        seed = 32'h60e4_e531;
        reset <= 1'b1;
        load_word = $urandom(seed);
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] <= fill_word(i);
        end
        dmem[16] <= load_word;
        dmem[17] <= $urandom;
        build_program(load_word);
        timeout_limit = prog_count * 4 + reset_cycles;
        store_idx = 0;
        exp_pc = '0;
        reached_end = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        // Check one instruction per cycle at the falling edge
        while (!reached_end) begin
            @(negedge clk);
            check_pc(pc, exp_pc);
            if (mem_write) begin
                if (store_idx >= exp_addr_q.size()) begin
                    abort_run($sformatf("Unexpected store to 0x%08h at time %0t",
                        data_addr, $time));
                end else begin
                    check_word("data_addr", data_addr, exp_addr_q[store_idx]);
                    check_word("write_data", write_data, exp_data_q[store_idx]);
                    store_idx++;
                end
            end
            reached_end = (pc == end_pc);
            exp_pc = predict_next_pc(exp_pc);
        end

        // The closing jal keeps the PC on itself
        @(negedge clk);
        check_pc(pc, exp_pc);

        if (store_idx == exp_addr_q.size()) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("End loop reached after %0d of %0d expected stores",
                store_idx, exp_addr_q.size()));
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
hw/rv_core_pkg.sv
hw/imm_extend.sv
hw/control_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/datapath.sv
hw/rv_core_top.sv
tests/rv_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV32I subset core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := rv_core_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) include/rv_core_program.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
